// ==== build.f ====
fb_reader_pkg.sv
sync_fifo.sv
fetch_splitter.sv
read_request_generator.sv
framebuffer_serializer.sv
framebuffer_reader.sv
tb_clock_gen.sv
framebuffer_reader_checker.sv
framebuffer_reader_tb.sv

// ==== fb_reader_pkg.sv ====
package fb_reader_pkg;

    ////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////
    localparam int ADDR_W                = 32;
    localparam int DATA_W                = 32;
    localparam int PIXEL_W               = 16;
    localparam int PIXELS_PER_BEAT       = 2;
    localparam int BEAT_BYTES            = 4;
    localparam int PIXEL_FIFO_DEPTH_LOG2 = 7;

    // Read address channel encodings for one incrementing beat of a full word
    localparam logic [7:0] AR_LEN   = 8'd0;
    localparam logic [2:0] AR_SIZE  = 3'($clog2(BEAT_BYTES));
    localparam logic [1:0] AR_BURST = 2'b01;

    ////////////////////////////////////////
    // Stream payloads
    ////////////////////////////////////////

    // Pixel index from the fragment stage
    typedef struct packed {
        logic [ADDR_W-1:0] index;
        logic              last;
    } fetch_t;

    // One pixel waiting for its memory word
    typedef struct packed {
        logic [ADDR_W-1:0] index;
        logic              lane;
        logic              new_word;
        logic              last;
    } pixel_entry_t;

    // Word aligned byte address
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } ar_req_t;

    // A read word seen raw or split into pixels with lane 0 in the low half
    typedef union packed {
        logic [DATA_W-1:0]                            raw;
        logic [PIXELS_PER_BEAT-1:0][PIXEL_W-1:0]      pixels;
    } mem_beat_u;

    typedef struct packed {
        logic [PIXEL_W-1:0] data;
        logic [ADDR_W-1:0]  index;
        logic               last;
    } frag_t;

endpackage

// ==== fetch_splitter.sv ====
`timescale 1ns/1ps

module fetch_splitter
    import fb_reader_pkg::*;
(
    input  logic              aclk,
    input  logic              i_reset,

    input  logic [ADDR_W-1:0] i_conf_addr,

    // Fetch stream from the fragment stage
    input  logic              i_fetch_valid,
    output logic              o_fetch_ready,
    input  fetch_t            i_fetch,

    // Request path to the read request generator
    output logic              o_req_valid,
    input  logic              i_req_ready,
    output ar_req_t           o_req,

    // Pixel path to the queue
    output logic              o_entry_wr,
    output pixel_entry_t      o_entry,
    input  logic              i_entry_full
);
    logic [ADDR_W-1:0] byte_addr;
    logic [ADDR_W-1:0] word_addr;
    logic              lane;
    logic              new_word;
    logic              accept;

    // Word tracking across accepted fetches
    logic [ADDR_W-1:0] prev_word;
    logic              after_last;

    ////////////////////////////////////////
    // Address rule
    ////////////////////////////////////////

    // Two bytes per pixel
    assign byte_addr = i_conf_addr + {i_fetch.index[ADDR_W-2:0], 1'b0};
    assign word_addr = byte_addr & ~ADDR_W'(BEAT_BYTES - 1);
    assign lane      = byte_addr[1];

    // First fetch, fetch after a last, or a different word
    assign new_word = after_last || (word_addr != prev_word);

    ////////////////////////////////////////
    // Fork with joint acceptance
    ////////////////////////////////////////

    // Both paths take the fetch in the same cycle or neither does
    assign o_fetch_ready = !i_entry_full && (!new_word || i_req_ready);
    assign accept        = i_fetch_valid && o_fetch_ready;

    assign o_req_valid = accept && new_word;
    assign o_req.addr  = word_addr;

    assign o_entry_wr        = accept;
    assign o_entry.index     = i_fetch.index;
    assign o_entry.lane      = lane;
    assign o_entry.new_word  = new_word;
    assign o_entry.last      = i_fetch.last;

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            after_last <= 1'b1;
        end else if (accept) begin
            after_last <= i_fetch.last;
        end
    end

    // Word address of the last accepted fetch
    always_ff @(posedge aclk) begin
        if (accept) begin
            prev_word <= word_addr;
        end
    end

endmodule

// ==== framebuffer_reader.sv ====
`timescale 1ns/1ps

module framebuffer_reader
    import fb_reader_pkg::*;
(
    input  logic              aclk,
    input  logic              i_reset,

    // Framebuffer base in bytes
    input  logic [ADDR_W-1:0] i_conf_addr,

    // Fetch stream
    input  logic              i_fetch_valid,
    output logic              o_fetch_ready,
    input  fetch_t            i_fetch,

    // Read address channel
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    output ar_req_t           o_ar,
    output logic [7:0]        o_ar_len,
    output logic [2:0]        o_ar_size,
    output logic [1:0]        o_ar_burst,

    // Read data channel; every burst is one beat so i_r_last carries nothing new
    input  logic              i_r_valid,
    output logic              o_r_ready,
    input  mem_beat_u         i_r_data,
    input  logic              i_r_last,

    // Fragment stream
    output logic              o_frag_valid,
    input  logic              i_frag_ready,
    output frag_t             o_frag
);
    logic         req_valid;
    logic         req_ready;
    ar_req_t      req;

    logic         entry_wr;
    pixel_entry_t entry_in;
    logic         entry_full;
    logic         entry_rd;
    pixel_entry_t entry_out;
    logic         entry_empty;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////
    fetch_splitter u_splitter (
        .aclk          (aclk),
        .i_reset       (i_reset),
        .i_conf_addr   (i_conf_addr),
        .i_fetch_valid (i_fetch_valid),
        .o_fetch_ready (o_fetch_ready),
        .i_fetch       (i_fetch),
        .o_req_valid   (req_valid),
        .i_req_ready   (req_ready),
        .o_req         (req),
        .o_entry_wr    (entry_wr),
        .o_entry       (entry_in),
        .i_entry_full  (entry_full)
    );

    // Pixels wait here while their words are in flight
    sync_fifo #(
        .WIDTH      ($bits(pixel_entry_t)),
        .DEPTH_LOG2 (PIXEL_FIFO_DEPTH_LOG2)
    ) u_pixel_fifo (
        .aclk    (aclk),
        .i_reset (i_reset),
        .i_wr    (entry_wr),
        .i_data  (entry_in),
        .o_full  (entry_full),
        .i_rd    (entry_rd),
        .o_data  (entry_out),
        .o_empty (entry_empty)
    );

    ////////////////////////////////////////
    // Memory side and output side
    ////////////////////////////////////////
    read_request_generator u_req_gen (
        .aclk        (aclk),
        .i_reset     (i_reset),
        .i_req_valid (req_valid),
        .o_req_ready (req_ready),
        .i_req       (req),
        .o_ar_valid  (o_ar_valid),
        .i_ar_ready  (i_ar_ready),
        .o_ar        (o_ar),
        .o_ar_len    (o_ar_len),
        .o_ar_size   (o_ar_size),
        .o_ar_burst  (o_ar_burst)
    );

    framebuffer_serializer u_serializer (
        .aclk          (aclk),
        .i_reset       (i_reset),
        .i_entry       (entry_out),
        .i_entry_empty (entry_empty),
        .o_entry_rd    (entry_rd),
        .i_r_valid     (i_r_valid),
        .o_r_ready     (o_r_ready),
        .i_r_data      (i_r_data),
        .o_frag_valid  (o_frag_valid),
        .i_frag_ready  (i_frag_ready),
        .o_frag        (o_frag)
    );

endmodule

// ==== framebuffer_reader_checker.sv ====
`timescale 1ns/1ps

module framebuffer_reader_checker
    import fb_reader_pkg::*;
(
    input logic                           aclk,
    input logic                           i_reset,
    input logic                           i_ar_valid,
    input logic                           i_ar_ready,
    input ar_req_t                        i_ar,
    input logic                           i_frag_valid,
    input logic                           i_frag_ready,
    input frag_t                          i_frag,
    input logic                           i_fetch_ready,
    input logic                           i_fifo_full,
    input logic [PIXEL_FIFO_DEPTH_LOG2:0] i_fifo_count
);
    // Both streams idle and the pixel queue empty right after reset
    a_reset_idle: assert property (@(posedge aclk)
        $fell(i_reset) |-> !i_ar_valid && !i_frag_valid && (i_fifo_count == '0))
    else begin
        $error("read address, fragment or pixel queue not idle after reset");
        framebuffer_reader_tb.checker_failures++;
    end

    ////////////////////////////////////////
    // Stream stability under back-pressure
    ////////////////////////////////////////
    a_ar_hold: assert property (@(posedge aclk) disable iff (i_reset)
        i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar))
    else begin
        $error("read request dropped or changed while stalled");
        framebuffer_reader_tb.checker_failures++;
    end

    a_frag_hold: assert property (@(posedge aclk) disable iff (i_reset)
        i_frag_valid && !i_frag_ready |=> i_frag_valid && $stable(i_frag))
    else begin
        $error("fragment dropped or changed while stalled");
        framebuffer_reader_tb.checker_failures++;
    end

    // Requests are whole words
    a_ar_aligned: assert property (@(posedge aclk) disable iff (i_reset)
        i_ar_valid |-> (i_ar.addr[1:0] == 2'b00))
    else begin
        $error("read address is not word aligned");
        framebuffer_reader_tb.checker_failures++;
    end

    a_full_blocks: assert property (@(posedge aclk) disable iff (i_reset)
        i_fifo_full |-> !i_fetch_ready)
    else begin
        $error("fetch accepted while the pixel queue is full");
        framebuffer_reader_tb.checker_failures++;
    end

endmodule

// ==== framebuffer_reader_tb.sv ====
`timescale 1ns/1ps

module framebuffer_reader_tb
    import fb_reader_pkg::*;
();
    localparam int TOTAL_FETCHES   = 64 + 11 + 5 + 256;
    localparam int WATCHDOG_CYCLES = TOTAL_FETCHES * 40 + 2000;

    logic              aclk;
    logic              i_reset;
    logic [ADDR_W-1:0] i_conf_addr;
    logic              i_fetch_valid;
    logic              o_fetch_ready;
    fetch_t            i_fetch;
    logic              o_ar_valid;
    logic              i_ar_ready;
    ar_req_t           o_ar;
    logic [7:0]        o_ar_len;
    logic [2:0]        o_ar_size;
    logic [1:0]        o_ar_burst;
    logic              i_r_valid;
    logic              o_r_ready;
    mem_beat_u         i_r_data;
    logic              i_r_last;
    logic              o_frag_valid;
    logic              i_frag_ready;
    frag_t             o_frag;

    string             test_name;
    int                errors;
    int                checker_failures;
    int                ready_mode;
    int                ar_seen;
    int                ar_expected;
    int                r_gap;
    logic [31:0]       lfsr;
    logic [ADDR_W-1:0] model_prev_word;
    logic              model_after_last;
    logic [ADDR_W-1:0] mem_q[$];
    logic [ADDR_W-1:0] exp_ars[$];
    frag_t             exp_frags[$];
    logic [ADDR_W-1:0] scatter [11] = '{4, 4, 5, 6, 40, 41, 41, 3, 2, 200, 201};

    tb_clock_gen #(.PERIOD_NS(8.0)) u_clock (.o_clk(aclk));

    framebuffer_reader DUT (.*);

    bind framebuffer_reader framebuffer_reader_checker u_checker (
        .aclk          (aclk),
        .i_reset       (i_reset),
        .i_ar_valid    (o_ar_valid),
        .i_ar_ready    (i_ar_ready),
        .i_ar          (o_ar),
        .i_frag_valid  (o_frag_valid),
        .i_frag_ready  (i_frag_ready),
        .i_frag        (o_frag),
        .i_fetch_ready (o_fetch_ready),
        .i_fifo_full   (u_pixel_fifo.o_full),
        .i_fifo_count  (u_pixel_fifo.count)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Pixel stored at a byte address is its half-word address scrambled
    function automatic logic [PIXEL_W-1:0] pixel_at(input logic [ADDR_W-1:0] byte_addr);
        return byte_addr[PIXEL_W:1] ^ 16'hA5C3;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic send_fetch(input logic [ADDR_W-1:0] index, input logic last);
        logic [ADDR_W-1:0] byte_addr;
        logic [ADDR_W-1:0] word_addr;
        frag_t             frag;
        i_fetch_valid = 1'b1;
        i_fetch.index = index;
        i_fetch.last  = last;
        do begin
            @(posedge aclk);
        end while (!o_fetch_ready);
        byte_addr = i_conf_addr + (index << 1);
        word_addr = {byte_addr[ADDR_W-1:2], 2'b00};
        // New word after reset, after a last, or on a word change
        if (model_after_last || (word_addr != model_prev_word)) begin
            exp_ars.push_back(word_addr);
            ar_expected++;
        end
        model_prev_word  = word_addr;
        model_after_last = last;
        frag.data  = pixel_at(byte_addr);
        frag.index = index;
        frag.last  = last;
        exp_frags.push_back(frag);
        #1 i_fetch_valid = 1'b0;
    endtask

    task automatic finish_run(input logic [31:0] requests);
        while (exp_frags.size() != 0 || exp_ars.size() != 0 || mem_q.size() != 0) begin
            @(posedge aclk);
            #1;
        end
        check_value("read requests", requests, ar_seen);
        ar_seen     = 0;
        ar_expected = 0;
    endtask

    ////////////////////////////////////////
    // Memory model and stream monitor
    ////////////////////////////////////////
    always @(posedge aclk) begin
        if (!i_reset) begin
            if (o_ar_valid && i_ar_ready) begin
                check_value("read address",
                            (exp_ars.size() != 0) ? exp_ars.pop_front() : 'x, o_ar.addr);
                check_value("read length", 8'd0, o_ar_len);
                check_value("read size", 3'd2, o_ar_size);
                check_value("read burst", 2'b01, o_ar_burst);
                mem_q.push_back(o_ar.addr);
                ar_seen++;
            end
            if (i_r_valid && o_r_ready) begin
                void'(mem_q.pop_front());
                r_gap = random_bits(2);
            end
            if (o_frag_valid && i_frag_ready) begin
                check_value("fragment",
                            (exp_frags.size() != 0) ? exp_frags.pop_front() : 'x, o_frag);
            end
        end
        #1;
        // Beats return in request order after a short random gap
        if (r_gap != 0) begin
            r_gap--;
        end
        i_r_valid = (mem_q.size() != 0) && (r_gap == 0);
        if (mem_q.size() != 0) begin
            i_r_data.pixels[0] = pixel_at(mem_q[0]);
            i_r_data.pixels[1] = pixel_at(mem_q[0] + 2);
        end
        // Mode 0 always ready, 1 random, 2 fragments stalled
        i_ar_ready   = (ready_mode == 0) || random_bits(1);
        i_frag_ready = (ready_mode == 0) || ((ready_mode == 1) && random_bits(1));
    end

    initial begin
        logic [ADDR_W-1:0] index;
        logic [1:0]        step;
        lfsr             = 32'heeee0f9b;
        errors           = 0;
        checker_failures = 0;
        ready_mode       = 0;
        ar_seen          = 0;
        ar_expected      = 0;
        r_gap            = 0;
        model_prev_word  = '0;
        model_after_last = 1'b1;
        i_reset          = 1'b1;
        i_conf_addr      = 32'h0000_8000;
        i_fetch_valid    = 1'b0;
        i_fetch          = '0;
        i_ar_ready       = 1'b1;
        i_r_valid        = 1'b0;
        i_r_data         = '0;
        i_r_last         = 1'b1;
        i_frag_ready     = 1'b1;
        repeat (16) @(posedge aclk);
        #1 i_reset = 1'b0;

        test_name = "sequential";
        for (int n = 0; n < 64; n++) begin
            send_fetch(n, n == 63);
        end
        finish_run(32);

        // Odd half-word base puts index 0 in lane 1
        test_name   = "scattered";
        i_conf_addr = 32'h0001_0002;
        for (int k = 0; k < 11; k++) begin
            send_fetch(scatter[k], k == 10);
        end
        finish_run(ar_expected);

        // First run ends mid-word and the next starts in that same word
        test_name   = "rebase";
        i_conf_addr = 32'h0004_0000;
        send_fetch(0, 1'b0);
        send_fetch(1, 1'b0);
        send_fetch(2, 1'b1);
        send_fetch(3, 1'b0);
        send_fetch(4, 1'b1);
        finish_run(ar_expected);

        // Output stalled until the queue fills, then random stalls on both sides
        test_name  = "backpressure";
        ready_mode = 2;
        index      = '0;
        fork
            for (int n = 0; n < 256; n++) begin
                step = random_bits(2);
                if (step == 2'd3) begin
                    index = random_bits(10);
                end else if (step != 2'd0) begin
                    index = index + 1;
                end
                send_fetch(index, (n == 255) || (random_bits(4) == 0));
            end
            begin
                repeat (250) @(posedge aclk);
                ready_mode = 1;
            end
        join
        finish_run(ar_expected);

        $display("Run complete: %0d mismatches, %0d assertion failures",
                 errors, checker_failures);
        if (errors == 0 && checker_failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Watchdog expired: fragments stopped arriving before all runs finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== framebuffer_serializer.sv ====
`timescale 1ns/1ps

module framebuffer_serializer
    import fb_reader_pkg::*;
(
    input  logic         aclk,
    input  logic         i_reset,

    // Pixel queue head
    input  pixel_entry_t i_entry,
    input  logic         i_entry_empty,
    output logic         o_entry_rd,

    // Read data channel
    input  logic         i_r_valid,
    output logic         o_r_ready,
    input  mem_beat_u    i_r_data,

    // Fragment stream
    output logic         o_frag_valid,
    input  logic         i_frag_ready,
    output frag_t        o_frag
);
    // Beat register; fresh means no new_word entry has claimed it yet
    mem_beat_u beat_q;
    logic      beat_held;
    logic      beat_fresh;

    logic      frag_valid_q;
    frag_t     frag_q;

    logic      head_new;
    logic      head_reuse;
    logic      r_fire;
    logic      out_free;
    logic      beat_ok;
    logic      pop;
    mem_beat_u sel_beat;

    assign head_new   = !i_entry_empty && i_entry.new_word;
    assign head_reuse = !i_entry_empty && !i_entry.new_word;

    ////////////////////////////////////////
    // Beat handling
    ////////////////////////////////////////

    // The claimed beat retires once the head asks for a new word
    assign o_r_ready = !beat_held || (!beat_fresh && head_new);
    assign r_fire    = i_r_valid && o_r_ready;

    // New word wants a fresh beat, held or arriving now
    assign beat_ok = (head_new && ((beat_held && beat_fresh) || r_fire))
                  || (head_reuse && beat_held && !beat_fresh);

    assign out_free = !frag_valid_q || i_frag_ready;
    assign pop      = beat_ok && out_free;

    assign o_entry_rd = pop;

    // A beat on the bus this cycle always belongs to the head
    assign sel_beat = r_fire ? i_r_data : beat_q;

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            beat_held  <= 1'b0;
            beat_fresh <= 1'b0;
        end else if (r_fire) begin
            beat_held  <= 1'b1;
            beat_fresh <= !pop;
        end else if (pop && i_entry.new_word) begin
            beat_fresh <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_fire) begin
            beat_q <= i_r_data;
        end
    end

    ////////////////////////////////////////
    // Fragment output register
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (i_reset) begin
            frag_valid_q <= 1'b0;
        end else if (pop) begin
            frag_valid_q <= 1'b1;
        end else if (i_frag_ready) begin
            frag_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            frag_q.data  <= sel_beat.pixels[i_entry.lane];
            frag_q.index <= i_entry.index;
            frag_q.last  <= i_entry.last;
        end
    end

    assign o_frag_valid = frag_valid_q;
    assign o_frag       = frag_q;

endmodule

// ==== read_request_generator.sv ====
`timescale 1ns/1ps

module read_request_generator
    import fb_reader_pkg::*;
(
    input  logic        aclk,
    input  logic        i_reset,

    // Request strobe from the splitter
    input  logic        i_req_valid,
    output logic        o_req_ready,
    input  ar_req_t     i_req,

    // Read address channel
    output logic        o_ar_valid,
    input  logic        i_ar_ready,
    output ar_req_t     o_ar,
    output logic [7:0]  o_ar_len,
    output logic [2:0]  o_ar_size,
    output logic [1:0]  o_ar_burst
);
    logic    ar_valid_q;
    ar_req_t ar_q;

    // Free slot, or the held request leaves this cycle
    assign o_req_ready = !ar_valid_q || i_ar_ready;

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            ar_valid_q <= 1'b0;
        end else if (o_req_ready) begin
            ar_valid_q <= i_req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_req_valid && o_req_ready) begin
            ar_q <= i_req;
        end
    end

    ////////////////////////////////////////
    // Channel outputs
    ////////////////////////////////////////
    assign o_ar_valid = ar_valid_q;
    assign o_ar       = ar_q;

    // Single beat of one word, incrementing
    assign o_ar_len   = AR_LEN;
    assign o_ar_size  = AR_SIZE;
    assign o_ar_burst = AR_BURST;

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic             aclk,
    input  logic             i_reset,

    input  logic             i_wr,
    input  logic [WIDTH-1:0] i_data,
    output logic             o_full,

    input  logic             i_rd,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty
);
    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_wr;
    logic                  do_rd;

    // Requests against a full or empty queue are dropped
    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    assign o_full  = (count == (DEPTH_LOG2 + 1)'(DEPTH));
    assign o_empty = (count == '0);

    // First word falls through to the output
    assign o_data = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule
